//--- Makefile
VERILATOR ?= verilator
TOP       ?= uop_crack_tb
FLIST     ?= uop_crack.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/uop_crack_pkg.sv
// Opcode values are local to this core and loads and stores place the data register in rd
`include "uop_crack_settings.svh"

package uop_crack_pkg;

	// ======================================================================
	// Opcodes
	// ======================================================================
	typedef enum logic [5:0]
	{
		OP_NOP   = 6'h00,
		OP_ADD   = 6'h01,
		OP_ADDI  = 6'h02,      // rd = rs1 + imm
		OP_LOAD  = 6'h04,      // rd = mem[rs1 + imm]
		OP_STORE = 6'h05,      // mem[rs1 + imm] = rd
		OP_PUSH  = 6'h08,      // imm[1:0]+1 regs from rd
		OP_POP   = 6'h09,
		OP_ENTER = 6'h0C,
		OP_EXIT  = 6'h0D,
		OP_BCC   = 6'h10,      // Condition in rs2[2:0]
		OP_RET   = 6'h11,      // Target in rs1
		OP_BRK   = 6'h3F
	} opcode_t;

	// Fixed 32-bit format
	// imm is the signed offset or addend, rs2 is spare except on BCC
	typedef struct packed
	{
		logic signed [10:0] imm;
		logic [4:0]         rs2;
		logic [4:0]         rs1;
		logic [4:0]         rd;
		opcode_t            opcode;
	} instruction_t;

	// ======================================================================
	// Micro-ops
	// ======================================================================
	typedef struct packed
	{
		logic         v;       // Slot holds a live micro-op
		logic [2:0]   count;   // Group size on slot 0 only
		logic [2:0]   num;     // Position within the group
		instruction_t ins;
	} micro_op_t;

	// Whole group as produced by the expander
	typedef micro_op_t [`UOP_MAX-1:0] uop_group_t;

	// Sequencer
	typedef enum logic
	{
		SEQ_IDLE,              // Waiting for an instruction
		SEQ_ISSUE              // Handing out micro-ops
	} seq_state_t;

endpackage

//--- common/uop_crack_settings.svh
// Register numbers are 5-bit literals and byte sizes are plain integers meant for offset math
`ifndef UOP_CRACK_SETTINGS_SVH
`define UOP_CRACK_SETTINGS_SVH

// ==========================================================================
// Group sizing
// ==========================================================================
`define UOP_MAX      8       // Slots carried per group
`define SLOT_BYTES   8       // One stack slot
`define FRAME_BYTES  32      // ENTER/EXIT frame footprint

// ==========================================================================
// Architectural registers touched by cracked sequences
// ==========================================================================
`define REG_SP  5'd31        // Stack pointer
`define REG_LR  5'd30        // Link register
`define REG_FP  5'd29        // Frame pointer
`define REG_LC  5'd28        // Loop counter

`endif

//--- common/uop_stream_if.sv
// Group is filled combinationally by the expander from ins and is valid only while valid is high
`timescale 1ns/1ps

interface uop_stream_if;
	import uop_crack_pkg::*;

	logic         valid;    // Offer pending
	logic         ready;    // Sequencer can take it
	instruction_t ins;      // Instruction from the granted thread
	logic         thread;   // Granted thread id
	uop_group_t   group;    // Expanded micro-ops for ins

	// Arbiter side
	modport src
	(
		output valid,
		output ins,
		output thread,
		input  ready
	);

	// Expander drives group and the sequencer drives ready
	modport dst
	(
		input  valid,
		input  ins,
		input  thread,
		output ready,
		output group
	);

endinterface

//--- cracker/uop_expander.sv
// Purely combinational with groups of at most five and PUSH/POP limited to four registers
`timescale 1ns/1ps
`include "uop_crack_settings.svh"

module uop_expander
(
	uop_stream_if.dst arb_bus
);
	import uop_crack_pkg::*;

	instruction_t ir;
	instruction_t slot [`UOP_MAX];   // Instructions in issue order
	logic [2:0]   cnt;               // Live slots
	logic [2:0]   n_regs;            // PUSH/POP register count
	uop_group_t   grp;

	// Build a single-source template instruction
	function automatic instruction_t mk_ins(opcode_t op, logic [4:0] rd, logic [4:0] rs1,
		logic signed [10:0] imm);
		instruction_t t;
		t.imm    = imm;
		t.rs2    = 5'd0;
		t.rs1    = rs1;
		t.rd     = rd;
		t.opcode = op;
		return t;
	endfunction

	assign ir     = arb_bus.ins;
	assign n_regs = {1'b0, ir.imm[1:0]} + 3'd1;

	// ======================================================================
	// Opcode translation
	// ======================================================================
	always_comb
	begin
		for (int i = 0; i < `UOP_MAX; i++)
			slot[i] = '0;
		cnt     = 3'd1;
		slot[0] = ir;                    // Pass-through unless overridden
		case (ir.opcode)
		OP_PUSH:
			begin
				// Stores walk down from SP then SP drops by the whole run
				for (int k = 0; k < 4; k++)
					if (k < int'(n_regs))
						slot[k] = mk_ins(OP_STORE, ir.rd + 5'(k), `REG_SP,
							11'(-`SLOT_BYTES * (k + 1)));
				slot[n_regs] = mk_ins(OP_ADDI, `REG_SP, `REG_SP,
					11'(-`SLOT_BYTES * int'(n_regs)));
				cnt = n_regs + 3'd1;
			end
		OP_POP:
			begin
				for (int k = 0; k < 4; k++)
					if (k < int'(n_regs))
						slot[k] = mk_ins(OP_LOAD, ir.rd + 5'(k), `REG_SP,
							11'(`SLOT_BYTES * k));
				slot[n_regs] = mk_ins(OP_ADDI, `REG_SP, `REG_SP,
					11'(`SLOT_BYTES * int'(n_regs)));
				cnt = n_regs + 3'd1;
			end
		OP_ENTER:
			begin
				slot[0] = mk_ins(OP_STORE, `REG_FP, `REG_SP, 11'(-`FRAME_BYTES));
				slot[1] = mk_ins(OP_ADDI, `REG_FP, `REG_SP, 11'sd0);   // FP = SP
				slot[2] = mk_ins(OP_STORE, `REG_LR, `REG_SP,
					11'(`SLOT_BYTES - `FRAME_BYTES));
				slot[3] = mk_ins(OP_ADDI, `REG_SP, `REG_SP, 11'(-`FRAME_BYTES));
				cnt     = 3'd4;
			end
		OP_EXIT:
			begin
				slot[0] = mk_ins(OP_ADDI, `REG_SP, `REG_FP, 11'sd0);   // SP = FP
				slot[1] = mk_ins(OP_LOAD, `REG_FP, `REG_SP, 11'sd0);
				slot[2] = mk_ins(OP_LOAD, `REG_LR, `REG_SP, 11'(`SLOT_BYTES));
				slot[3] = mk_ins(OP_ADDI, `REG_SP, `REG_SP, 11'(`FRAME_BYTES));
				slot[4] = mk_ins(OP_RET, 5'd0, `REG_LR, 11'sd0);       // Return via LR
				cnt     = 3'd5;
			end
		OP_BCC:
			// Conditions 2 and 5 leave the loop counter alone
			if (ir.rs2[2:0] != 3'd2 && ir.rs2[2:0] != 3'd5)
			begin
				slot[0] = mk_ins(OP_ADDI, `REG_LC, `REG_LC, -11'sd1);
				slot[1] = ir;
				cnt     = 3'd2;
			end
		default:
			cnt = 3'd1;                  // ADD, ADDI, LOAD, STORE, NOP, RET, BRK
		endcase
	end

	// Stamp valid, position and size onto each slot
	always_comb
	begin
		for (int i = 0; i < `UOP_MAX; i++)
		begin
			grp[i].v     = (i < int'(cnt));
			grp[i].count = (i == 0) ? cnt : 3'd0;   // Size rides on slot 0 only
			grp[i].num   = 3'(i);
			grp[i].ins   = slot[i];
		end
	end

	assign arb_bus.group = grp;

endmodule

//--- cracker/uop_sequencer.sv
// Accepting begins the cycle after reset releases and outputs hold while uop_ready is low
`timescale 1ns/1ps

module uop_sequencer
(
	input  logic                        clk,
	input  logic                        rst,
	uop_stream_if.dst                   arb_bus,
	output logic                        uop_valid,
	input  logic                        uop_ready,
	output uop_crack_pkg::instruction_t uop_ins,
	output logic [2:0]                  uop_num,
	output logic [2:0]                  uop_count,
	output logic                        uop_thread
);
	import uop_crack_pkg::*;

	seq_state_t state;
	uop_group_t grp;        // Captured group
	logic       thr;        // Owning thread
	logic [2:0] idx;        // Slot on the output
	logic       armed;      // Out of reset
	logic       uop_xfer;
	logic       last_uop;   // Final slot is transferring
	logic       accept;

	// ======================================================================
	// Output side
	// ======================================================================
	assign uop_valid  = (state == SEQ_ISSUE);
	assign uop_ins    = grp[idx].ins;
	assign uop_num    = grp[idx].num;
	assign uop_count  = grp[idx].count;
	assign uop_thread = thr;

	assign uop_xfer = uop_valid & uop_ready;
	assign last_uop = uop_xfer & (grp[idx].num == grp[0].count - 3'd1);

	// Take a new group when idle or as the last one drains
	assign arb_bus.ready = armed & ((state == SEQ_IDLE) | last_uop);
	assign accept        = arb_bus.valid & arb_bus.ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= SEQ_IDLE;
			idx   <= 3'd0;
			armed <= 1'b0;
		end
		else
		begin
			armed <= 1'b1;
			if (accept)
			begin
				state <= SEQ_ISSUE;          // Back-to-back reload lands here too
				idx   <= 3'd0;
			end
			else if (last_uop)
				state <= SEQ_IDLE;
			else if (uop_xfer)
				idx <= idx + 3'd1;
		end
	end

	// Payload capture
	always_ff @(posedge clk)
		if (accept)
		begin
			grp <= arb_bus.group;
			thr <= arb_bus.thread;
		end

endmodule

//--- sim/uop_crack_assert.sv
// Bound into uop_sequencer and checks only its micro-op output handshake
`timescale 1ns/1ps

module uop_crack_assert
(
	input logic                        clk,
	input logic                        rst,
	input logic                        uop_valid,
	input logic                        uop_ready,
	input uop_crack_pkg::instruction_t uop_ins,
	input logic [2:0]                  uop_num,
	input logic [2:0]                  uop_count,
	input logic                        uop_thread
);

	// Sequencer sits idle after any reset cycle
	a_reset_idle: assert property (@(posedge clk) rst |=> !uop_valid)
		else $error("uop_valid high after a reset cycle");

	// Stalled micro-op keeps its payload
	a_hold: assert property (@(posedge clk) disable iff (rst)
		uop_valid && !uop_ready |=> uop_valid && $stable(uop_ins) && $stable(uop_num)
		&& $stable(uop_count) && $stable(uop_thread))
		else $error("micro-op output changed under back-pressure");

	a_count_slot0: assert property (@(posedge clk) disable iff (rst)
		uop_valid && uop_count != 3'd0 |-> uop_num == 3'd0)   // Size only on slot 0
		else $error("uop_count nonzero on a slot other than 0");

endmodule

bind uop_sequencer uop_crack_assert uop_crack_assert_i
(
	.clk        (clk),
	.rst        (rst),
	.uop_valid  (uop_valid),
	.uop_ready  (uop_ready),
	.uop_ins    (uop_ins),
	.uop_num    (uop_num),
	.uop_count  (uop_count),
	.uop_thread (uop_thread)
);

//--- sim/uop_crack_tb.sv
// Directed tests run in sequence and the random back-pressure test runs last since it ends early
`timescale 1ns/1ps
`include "uop_crack_settings.svh"

module uop_crack_tb;
	import uop_crack_pkg::*;

	localparam int WAIT_LIMIT = 200;   // Cycles per wait loop

	logic         clk;
	logic         rst;
	logic         t0_valid;
	logic         t0_ready;
	instruction_t t0_ins;
	logic         t1_valid;
	logic         t1_ready;
	instruction_t t1_ins;
	logic         uop_valid;
	logic         uop_ready;
	instruction_t uop_ins;
	logic [2:0]   uop_num;
	logic [2:0]   uop_count;
	logic         uop_thread;

	logic [15:0] lfsr;
	micro_op_t   exp_uops [$];       // Model output in order
	logic        exp_thr [$];
	micro_op_t   got_uops [$];       // Every output transfer
	logic        got_thr [$];
	logic        acc_thr [$];        // Thread of each accepted instruction
	int          acc_cyc [$];
	int          xfer_cyc [$];
	int          cycle = 0;
	int          mon_errors = 0;     // Counted by the monitor
	logic [2:0]  cur_size = 3'd0;    // Size of the group on the output
	int          got_base;
	int          xfer_base;
	int          errors;
	int          test_err;
	int          tests_passed;
	int          tests_failed;
	logic        ready_watch;
	logic        stop_toggle;

	uop_crack_top uop_crack_top_i (.*);

	always #5 clk = ~clk;

	// ======================================================================
	// Stimulus helpers and reference model
	// ======================================================================
	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] lfsr_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[14:0], lfsr[0]};
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return r;
	endfunction

	function automatic instruction_t rand_ins(input opcode_t op);
		instruction_t ins;
		ins.imm    = 11'(lfsr_bits(11));
		ins.rs2    = 5'(lfsr_bits(5));
		ins.rs1    = 5'(lfsr_bits(5));
		ins.rd     = 5'(lfsr_bits(5));
		ins.opcode = op;
		return ins;
	endfunction

	function automatic instruction_t pack_ins(input opcode_t op, input logic [4:0] rd,
		input logic [4:0] rs1, input int imm);
		instruction_t ins;
		ins.imm    = 11'(imm);
		ins.rs2    = 5'd0;
		ins.rs1    = rs1;
		ins.rd     = rd;
		ins.opcode = op;
		return ins;
	endfunction

	// Appends the expected group of one accepted instruction
	task automatic expect_group(input instruction_t ins, input logic thr);
		instruction_t seq [$];
		micro_op_t    m;
		int           n;
		n = int'(ins.imm[1:0]) + 1;
		case (ins.opcode)
		OP_PUSH:
			begin
				for (int k = 0; k < n; k++)
					seq.push_back(pack_ins(OP_STORE, ins.rd + 5'(k), `REG_SP,
						-`SLOT_BYTES * (k + 1)));
				seq.push_back(pack_ins(OP_ADDI, `REG_SP, `REG_SP, -`SLOT_BYTES * n));
			end
		OP_POP:
			begin
				for (int k = 0; k < n; k++)
					seq.push_back(pack_ins(OP_LOAD, ins.rd + 5'(k), `REG_SP, `SLOT_BYTES * k));
				seq.push_back(pack_ins(OP_ADDI, `REG_SP, `REG_SP, `SLOT_BYTES * n));
			end
		OP_ENTER:
			begin
				seq.push_back(pack_ins(OP_STORE, `REG_FP, `REG_SP, -`FRAME_BYTES));
				seq.push_back(pack_ins(OP_ADDI, `REG_FP, `REG_SP, 0));
				seq.push_back(pack_ins(OP_STORE, `REG_LR, `REG_SP, -(`FRAME_BYTES - `SLOT_BYTES)));
				seq.push_back(pack_ins(OP_ADDI, `REG_SP, `REG_SP, -`FRAME_BYTES));
			end
		OP_EXIT:
			begin
				seq.push_back(pack_ins(OP_ADDI, `REG_SP, `REG_FP, 0));
				seq.push_back(pack_ins(OP_LOAD, `REG_FP, `REG_SP, 0));
				seq.push_back(pack_ins(OP_LOAD, `REG_LR, `REG_SP, `SLOT_BYTES));
				seq.push_back(pack_ins(OP_ADDI, `REG_SP, `REG_SP, `FRAME_BYTES));
				seq.push_back(pack_ins(OP_RET, 5'd0, `REG_LR, 0));
			end
		OP_BCC:
			begin
				if (ins.rs2[2:0] != 3'd2 && ins.rs2[2:0] != 3'd5)
					seq.push_back(pack_ins(OP_ADDI, `REG_LC, `REG_LC, -1));   // Loop count
				seq.push_back(ins);
			end
		default:
			seq.push_back(ins);
		endcase
		for (int i = 0; i < seq.size(); i++)
		begin
			m.v     = 1'b1;
			m.count = (i == 0) ? 3'(seq.size()) : 3'd0;
			m.num   = 3'(i);
			m.ins   = seq[i];
			exp_uops.push_back(m);
			exp_thr.push_back(thr);
		end
	endtask

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_uop(input micro_op_t exp, input logic exp_t, input micro_op_t got,
		input logic got_t);
		if (got.ins !== exp.ins)
		begin
			$display("Error at %0t: uop_ins expected %h got %h", $time, exp.ins, got.ins);
			errors++;
		end
		if (got.num !== exp.num || got.count !== exp.count)
		begin
			$display("Error at %0t: uop_num/uop_count expected %0d/%0d got %0d/%0d",
				$time, exp.num, exp.count, got.num, got.count);
			errors++;
		end
		if (got_t !== exp_t)
		begin
			$display("Error at %0t: uop_thread expected %0d got %0d", $time, exp_t, got_t);
			errors++;
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
			mon_errors++;
		end
	endtask

	// Output monitor, sampled on the rising edge
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (!rst && uop_valid)
		begin
			if (uop_num == 3'd0)
				cur_size = uop_count;
			if (ready_watch && !(uop_ready && uop_num == cur_size - 3'd1))
			begin
				check_ready("t0_ready", t0_ready, 1'b0);   // Group still draining
				check_ready("t1_ready", t1_ready, 1'b0);
			end
			if (uop_ready)
			begin
				got_uops.push_back({1'b1, uop_count, uop_num, uop_ins});
				got_thr.push_back(uop_thread);
				xfer_cyc.push_back(cycle);
			end
		end
	end

	// ======================================================================
	// Drive and wait tasks
	// ======================================================================
	task automatic send_one(input logic thr, input instruction_t ins);
		logic taken;
		int   waited;
		@(negedge clk);
		if (thr)
		begin
			t1_valid = 1'b1;
			t1_ins   = ins;
		end
		else
		begin
			t0_valid = 1'b1;
			t0_ins   = ins;
		end
		taken  = 1'b0;
		waited = 0;
		while (!taken && waited < WAIT_LIMIT)
		begin
			@(posedge clk);
			taken = thr ? t1_ready : t0_ready;       // Valid is ours, so ready means transfer
			waited++;
		end
		if (taken)
		begin
			expect_group(ins, thr);
			acc_thr.push_back(thr);
			acc_cyc.push_back(cycle);
		end
		else
		begin
			$display("Timeout: thread %0d instruction was never accepted", thr);
			errors++;
		end
	endtask

	task automatic idle_thread(input logic thr);
		@(negedge clk);
		if (thr)
			t1_valid = 1'b0;
		else
			t0_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (got_uops.size() - got_base < exp_uops.size() && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (got_uops.size() - got_base < exp_uops.size())
		begin
			$display("Timeout: only %0d of %0d micro-ops came out",
				got_uops.size() - got_base, exp_uops.size());
			errors++;
		end
	endtask

	task automatic start_test();
		test_err = errors + mon_errors;
		exp_uops.delete();
		exp_thr.delete();
		acc_thr.delete();
		acc_cyc.delete();
		got_base  = got_uops.size();
		xfer_base = xfer_cyc.size();
	endtask

	task automatic finish_test(input string name);
		if (got_uops.size() - got_base != exp_uops.size())
		begin
			$display("Error at %0t: micro-op count expected %0d got %0d", $time,
				exp_uops.size(), got_uops.size() - got_base);
			errors++;
		end
		for (int i = 0; i < exp_uops.size() && got_base + i < got_uops.size(); i++)
			check_uop(exp_uops[i], exp_thr[i], got_uops[got_base + i], got_thr[got_base + i]);
		if (errors + mon_errors == test_err)
		begin
			$display("Test %s: pass", name);
			tests_passed++;
		end
		else
		begin
			$display("Test %s: FAIL", name);
			tests_failed++;
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic test_passthrough();
		opcode_t ops [6];
		ops = '{OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, OP_NOP, OP_BRK};
		start_test();
		foreach (ops[i])
			send_one(1'b0, rand_ins(ops[i]));
		idle_thread(1'b0);
		wait_drain();
		finish_test("passthrough");
	endtask

	task automatic test_push_pop();
		instruction_t ins;
		start_test();
		for (int n = 1; n <= 4; n++)
		begin
			ins = rand_ins(OP_PUSH);
			ins.imm[1:0] = 2'(n - 1);
			send_one(1'b1, ins);
			ins = rand_ins(OP_POP);
			ins.imm[1:0] = 2'(n - 1);
			send_one(1'b1, ins);
		end
		idle_thread(1'b1);
		wait_drain();
		finish_test("push_pop");
	endtask

	task automatic test_frame_bcc();
		instruction_t ins;
		start_test();
		send_one(1'b0, rand_ins(OP_ENTER));
		send_one(1'b0, rand_ins(OP_EXIT));
		for (int c = 0; c < 8; c++)
		begin
			ins = rand_ins(OP_BCC);
			ins.rs2[2:0] = 3'(c);                  // Every branch condition
			send_one(1'b0, ins);
		end
		idle_thread(1'b0);
		wait_drain();
		finish_test("frame_bcc");
	endtask

	task automatic test_two_threads();
		start_test();
		fork
			begin
				send_one(1'b0, pack_ins(OP_PUSH, 5'd3, 5'd0, 1));
				send_one(1'b0, pack_ins(OP_ENTER, 5'd0, 5'd0, 0));
				send_one(1'b0, pack_ins(OP_EXIT, 5'd0, 5'd0, 0));
				idle_thread(1'b0);
			end
			begin
				send_one(1'b1, pack_ins(OP_POP, 5'd8, 5'd0, 2));
				send_one(1'b1, pack_ins(OP_BCC, 5'd0, 5'd4, 12));
				send_one(1'b1, pack_ins(OP_PUSH, 5'd16, 5'd0, 3));
				idle_thread(1'b1);
			end
		join
		wait_drain();
		for (int i = 1; i < acc_thr.size(); i++)
			if (acc_thr[i] == acc_thr[i - 1])
			begin
				$display("Thread grants did not alternate at instruction %0d", i);
				errors++;
			end
		finish_test("two_threads");
	endtask

	task automatic test_back_to_back();
		start_test();
		uop_ready = 1'b1;
		for (int i = 0; i < 6; i++)
			send_one(1'b0, rand_ins(OP_ADD));
		idle_thread(1'b0);
		wait_drain();
		if (xfer_cyc.size() > xfer_base && acc_cyc.size() > 0
			&& xfer_cyc[xfer_base] != acc_cyc[0] + 1)
		begin
			$display("Error at %0t: first transfer cycle expected %0d got %0d", $time,
				acc_cyc[0] + 1, xfer_cyc[xfer_base]);
			errors++;
		end
		for (int i = xfer_base + 1; i < xfer_cyc.size(); i++)
			if (xfer_cyc[i] != xfer_cyc[i - 1] + 1)
			begin
				$display("Error at %0t: transfer cycle expected %0d got %0d", $time,
					xfer_cyc[i - 1] + 1, xfer_cyc[i]);
				errors++;
			end
		finish_test("back_to_back");
	endtask

	task automatic test_backpressure();
		start_test();
		ready_watch = 1'b1;
		stop_toggle = 1'b0;
		fork
			begin
				fork
					begin
						send_one(1'b0, pack_ins(OP_PUSH, 5'd4, 5'd0, 3));
						send_one(1'b0, pack_ins(OP_EXIT, 5'd0, 5'd0, 0));
						send_one(1'b0, rand_ins(OP_ADD));
						idle_thread(1'b0);
					end
					begin
						send_one(1'b1, pack_ins(OP_ENTER, 5'd0, 5'd0, 0));
						send_one(1'b1, pack_ins(OP_BCC, 5'd0, 5'd0, 1));
						send_one(1'b1, pack_ins(OP_POP, 5'd10, 5'd0, 1));
						idle_thread(1'b1);
					end
				join
				wait_drain();
				stop_toggle = 1'b1;
			end
			while (!stop_toggle)
			begin
				@(negedge clk);
				uop_ready = (lfsr_bits(1) != 16'd0);   // Random stall pattern
			end
		join
		ready_watch = 1'b0;
		@(negedge clk);
		uop_ready = 1'b1;
		finish_test("backpressure");
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		clk          = 1'b0;
		rst          = 1'b1;
		t0_valid     = 1'b0;
		t0_ins       = '0;
		t1_valid     = 1'b0;
		t1_ins       = '0;
		uop_ready    = 1'b1;
		lfsr         = 16'd65519;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		ready_watch  = 1'b0;
		stop_toggle  = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_passthrough();
		test_push_pop();
		test_frame_bcc();
		test_two_threads();
		test_back_to_back();
		test_backpressure();
		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors + mon_errors);
		if (errors + mon_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Hard limit on the whole run
	initial
	begin
		#200000;
		$display("Timeout: the run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- src/thread_arbiter.sv
// Threads must hold valid and the instruction until ready and the grant sticks while a stall lasts
`timescale 1ns/1ps

module thread_arbiter
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        t0_valid,
	output logic                        t0_ready,
	input  uop_crack_pkg::instruction_t t0_ins,
	input  logic                        t1_valid,
	output logic                        t1_ready,
	input  uop_crack_pkg::instruction_t t1_ins,
	uop_stream_if.src                   arb_bus
);

	logic last_win;   // Thread that took the last transfer
	logic lock;       // An offer is stalled on ready
	logic lock_sel;   // Thread owning the stalled offer
	logic sel;        // Current grant
	logic xfer;

	// Grant choice
	always_comb
	begin
		if (lock)
			sel = lock_sel;                   // Keep the stalled offer steady
		else if (t0_valid && t1_valid)
			sel = ~last_win;                  // Both asking so the loser of last round wins
		else
			sel = t1_valid;                   // Only one or none asking
	end

	assign arb_bus.valid  = sel ? t1_valid : t0_valid;
	assign arb_bus.ins    = sel ? t1_ins : t0_ins;
	assign arb_bus.thread = sel;

	// Ready goes back to the granted thread only
	assign t0_ready = arb_bus.ready & ~sel;
	assign t1_ready = arb_bus.ready & sel;

	assign xfer = arb_bus.valid & arb_bus.ready;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			last_win <= 1'b1;                 // Thread 0 has first priority
			lock     <= 1'b0;
			lock_sel <= 1'b0;
		end
		else if (xfer)
		begin
			last_win <= sel;
			lock     <= 1'b0;
		end
		else if (arb_bus.valid)
		begin
			lock     <= 1'b1;                 // Waiting on the sequencer
			lock_sel <= sel;
		end
	end

endmodule

//--- src/uop_crack_top.sv
// Two threads share one cracker and the first micro-op follows an accepted instruction by one cycle
`timescale 1ns/1ps

module uop_crack_top
(
	input  logic                        clk,
	input  logic                        rst,
	// Thread 0 instruction stream
	input  logic                        t0_valid,
	output logic                        t0_ready,
	input  uop_crack_pkg::instruction_t t0_ins,
	// Thread 1 instruction stream
	input  logic                        t1_valid,
	output logic                        t1_ready,
	input  uop_crack_pkg::instruction_t t1_ins,
	// Micro-op output
	output logic                        uop_valid,
	input  logic                        uop_ready,
	output uop_crack_pkg::instruction_t uop_ins,
	output logic [2:0]                  uop_num,
	output logic [2:0]                  uop_count,
	output logic                        uop_thread
);

	// ======================================================================
	// Arbiter -> expander -> sequencer
	// ======================================================================
	uop_stream_if arb_bus();

	thread_arbiter thread_arbiter_i
	(
		.clk      (clk),
		.rst      (rst),
		.t0_valid (t0_valid),
		.t0_ready (t0_ready),
		.t0_ins   (t0_ins),
		.t1_valid (t1_valid),
		.t1_ready (t1_ready),
		.t1_ins   (t1_ins),
		.arb_bus  (arb_bus.src)
	);

	uop_expander uop_expander_i (.arb_bus(arb_bus.dst));   // Fills arb_bus.group

	uop_sequencer uop_sequencer_i
	(
		.clk        (clk),
		.rst        (rst),
		.arb_bus    (arb_bus.dst),
		.uop_valid  (uop_valid),
		.uop_ready  (uop_ready),
		.uop_ins    (uop_ins),
		.uop_num    (uop_num),
		.uop_count  (uop_count),
		.uop_thread (uop_thread)
	);

endmodule

//--- uop_crack.f
+incdir+common
common/uop_crack_pkg.sv
common/uop_stream_if.sv
src/thread_arbiter.sv
cracker/uop_expander.sv
cracker/uop_sequencer.sv
src/uop_crack_top.sv
sim/uop_crack_assert.sv
sim/uop_crack_tb.sv
